//--- cp0.f
cp0_pkg.sv
cp0_timer.sv
cp0_exc_unit.sv
cp0_write_arbiter.sv
cp0_regs.sv
cp0_read_mux.sv
cp0_top.sv
cp0_tb_clk.sv
cp0_assert.sv
cp0_tb.sv

//--- Bender.yml
package:
  name: cp0

sources:
  - cp0_pkg.sv
  - cp0_timer.sv
  - cp0_exc_unit.sv
  - cp0_write_arbiter.sv
  - cp0_regs.sv
  - cp0_read_mux.sv
  - cp0_top.sv
  - target: test
    files:
      - cp0_tb_clk.sv
      - cp0_assert.sv
      - cp0_tb.sv

//--- cp0_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;
	import cp0_pkg::*;

	localparam word_t EXC_VEC  = 32'hbfc0_0380;
	localparam word_t PRID_VAL = 32'h0001_8000;
	localparam int    SEED     = 32'ha82f9d1f;

	logic      clk;
	logic      rst_n;
	logic      wcp0;
	logic      eret;
	logic      is_delayslot;
	reg_addr_t waddr;
	reg_addr_t raddr;
	reg_sel_t  wsel;
	reg_sel_t  rsel;
	word_t     wdata;
	word_t     victim_inst_addr;
	word_t     badvaddr;
	exc_vec_t  exc_type;
	hw_irq_t   int_i;
	word_t     cop0_data;
	logic      exc_en;
	word_t     pc_exc;

	int    value_errors;
	int    timeout_errors;
	int    seed_ret;
	word_t epc_exp;  // model of EPC
	word_t bad_exp;  // model of BadVAddr
	word_t cmp_exp;  // model of Compare

	cp0_tb_clk #(.PERIOD_NS(20)) clk_gen (.clk(clk));

	cp0_top #(
		.EXC_VECTOR(EXC_VEC),
		.PRID_VALUE(PRID_VAL)
	) dut0 (
		.clk(clk), .rst_n(rst_n), .wcp0(wcp0), .eret(eret), .is_delayslot(is_delayslot),
		.waddr(waddr), .raddr(raddr), .wsel(wsel), .rsel(rsel), .wdata(wdata),
		.victim_inst_addr(victim_inst_addr), .badvaddr(badvaddr), .exc_type(exc_type),
		.int_i(int_i), .cop0_data(cop0_data), .exc_en(exc_en), .pc_exc(pc_exc)
	);

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act)
		begin
			value_errors++;
			$display("ERROR %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_code(input string name, input exc_code_t exp, input exc_code_t act);
		if (exp !== act)
		begin
			value_errors++;
			$display("ERROR %s: expected code %0d, actual code %0d", name, exp, act);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;  // inputs change just after the edge
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		next_cycle();
		wcp0  = 1'b1;
		waddr = addr;
		wsel  = REG_SEL0;
		wdata = data;
		next_cycle();
		wcp0  = 1'b0;
	endtask

	task automatic read_reg(input reg_addr_t addr, output word_t data);
		next_cycle();
		raddr = addr;
		rsel  = REG_SEL0;
		@(negedge clk);
		data = cop0_data;
	endtask

	// mtc0 and mfc0 on the same register in one cycle
	task automatic bypass_write(input reg_addr_t addr, input word_t data, output word_t seen);
		next_cycle();
		wcp0  = 1'b1;
		waddr = addr;
		wsel  = REG_SEL0;
		wdata = data;
		raddr = addr;
		rsel  = REG_SEL0;
		@(negedge clk);
		seen = cop0_data;
		next_cycle();
		wcp0 = 1'b0;
	endtask

	task automatic check_fetch(input string name, input logic exp_en, input word_t exp_pc);
		@(negedge clk);
		check_word({name, " exc_en"}, {31'd0, exp_en}, {31'd0, exc_en});
		check_word({name, " pc_exc"}, exp_pc, pc_exc);
	endtask

	task automatic raise_exc(input string name, input exc_vec_t flags, input word_t victim,
		input logic ds, input word_t bad);
		next_cycle();
		exc_type         = flags;
		victim_inst_addr = victim;
		is_delayslot     = ds;
		badvaddr         = bad;
		check_fetch(name, 1'b1, EXC_VEC);
		next_cycle();  // commit edge
		exc_type     = '0;
		is_delayslot = 1'b0;
	endtask

	task automatic check_entry(input string name, input exc_code_t code, input logic bd,
		input word_t epc_e, input word_t bad_e);
		word_t v;
		read_reg(REG_EPC, v);
		check_word({name, " epc"}, epc_e, v);
		read_reg(REG_CAUSE, v);
		check_code({name, " exccode"}, code, v[CAUSE_EXC_HI:CAUSE_EXC_LO]);
		check_word({name, " bd"}, {31'd0, bd}, {31'd0, v[CAUSE_BD]});
		read_reg(REG_STATUS, v);
		check_word({name, " exl"}, 32'd1, {31'd0, v[STATUS_EXL]});
		read_reg(REG_BADVADDR, v);
		check_word({name, " badvaddr"}, bad_e, v);
	endtask

	task automatic test_reg_access();
		word_t d;
		word_t v;
		d = $urandom;
		bypass_write(REG_STATUS, d, v);
		check_word("reg_access status bypass", 32'h0040_0000 | (d & 32'h0000_ff03), v);
		read_reg(REG_STATUS, v);
		check_word("reg_access status", 32'h0040_0000 | (d & 32'h0000_ff03), v);
		write_reg(REG_STATUS, '0);
		d = $urandom;
		bypass_write(REG_EPC, d, v);
		check_word("reg_access epc bypass", d, v);
		read_reg(REG_EPC, v);
		check_word("reg_access epc", d, v);
		epc_exp = d;
		d = $urandom | 32'h8000_0000;  // far above count, no timer match
		bypass_write(REG_COMPARE, d, v);
		check_word("reg_access compare bypass", d, v);
		read_reg(REG_COMPARE, v);
		check_word("reg_access compare", d, v);
		cmp_exp = d;
		read_reg(REG_PRID, v);
		check_word("reg_access prid", PRID_VAL, v);
		read_reg(5'd3, v);
		check_word("reg_access unknown", '0, v);
		next_cycle();
		raddr = REG_STATUS;
		rsel  = 3'd1;  // nonzero select is unmapped
		@(negedge clk);
		check_word("reg_access select 1", '0, cop0_data);
	endtask

	task automatic test_exc_entry();
		word_t victim;
		word_t bad;
		int    ds;
		for (ds = 0; ds < 2; ds++)
		begin
			write_reg(REG_STATUS, '0);
			victim = $urandom & ~32'h3;
			bad    = $urandom;
			raise_exc("exc_entry sys", 32'd1 << EXCB_SYS, victim, ds[0], bad);
			epc_exp = ds ? victim - 32'd4 : victim;
			check_entry("exc_entry sys", EXC_SYS, ds[0], epc_exp, bad_exp);
			write_reg(REG_STATUS, '0);
			victim = ($urandom & ~32'h3) | 32'h2;  // misaligned fetch
			raise_exc("exc_entry adel", 32'd1 << EXCB_ADEL, victim, ds[0], bad);
			epc_exp = ds ? victim - 32'd4 : victim;
			bad_exp = victim;
			check_entry("exc_entry adel", EXC_ADEL, ds[0], epc_exp, bad_exp);
		end
	endtask

	task automatic test_nesting();
		word_t victim;
		word_t bad;
		word_t v;
		write_reg(REG_STATUS, '0);
		victim = $urandom & ~32'h3;
		raise_exc("nest first", 32'd1 << EXCB_BP, victim, 1'b0, $urandom);
		epc_exp = victim;
		raise_exc("nest second", 32'd1 << EXCB_SYS, $urandom & ~32'h3, 1'b1, $urandom);
		check_entry("nest second", EXC_SYS, 1'b0, epc_exp, bad_exp);
		write_reg(REG_STATUS, '0);
		victim = $urandom & ~32'h3;
		bad    = $urandom;
		raise_exc("prio ades", (32'd1 << EXCB_ADES) | (32'd1 << EXCB_OV), victim, 1'b0, bad);
		epc_exp = victim;
		bad_exp = bad;
		check_entry("prio ades", EXC_ADES, 1'b0, epc_exp, bad_exp);
		write_reg(REG_STATUS, '0);
		victim = $urandom & ~32'h3;  // aligned, so BadVAddr comes from badvaddr
		bad    = $urandom;
		raise_exc("prio adel", (32'd1 << EXCB_ADEL) | (32'd1 << EXCB_SYS), victim, 1'b0, bad);
		epc_exp = victim;
		bad_exp = bad;
		check_entry("prio adel", EXC_ADEL, 1'b0, epc_exp, bad_exp);
		write_reg(REG_STATUS, '0);
		victim = $urandom & ~32'h3;
		raise_exc("prio bp", (32'd1 << EXCB_TR) | (32'd1 << EXCB_BP), victim, 1'b0, $urandom);
		epc_exp = victim;
		check_entry("prio bp", EXC_BP, 1'b0, epc_exp, bad_exp);
		write_reg(REG_STATUS, '0);
		victim = $urandom & ~32'h3;
		raise_exc("prio ri", (32'd1 << EXCB_RI1) | (32'd1 << EXCB_OV), victim, 1'b0, $urandom);
		epc_exp = victim;
		check_entry("prio ri", EXC_RI, 1'b0, epc_exp, bad_exp);
		write_reg(REG_STATUS, '0);
		victim = $urandom & ~32'h3;
		next_cycle();
		exc_type         = 32'd1 << EXCB_SYS;
		victim_inst_addr = victim;
		wcp0             = 1'b1;
		waddr            = REG_COMPARE;
		wsel             = REG_SEL0;
		wdata            = $urandom;
		next_cycle();
		exc_type = '0;
		wcp0     = 1'b0;
		epc_exp  = victim;
		read_reg(REG_COMPARE, v);
		check_word("nest dropped mtc0", cmp_exp, v);
		read_reg(REG_EPC, v);
		check_word("nest dropped mtc0 epc", epc_exp, v);
	endtask

	task automatic test_eret();
		word_t d;
		word_t v;
		next_cycle();
		eret = 1'b1;
		check_fetch("eret", 1'b1, epc_exp);
		next_cycle();
		eret = 1'b0;
		read_reg(REG_STATUS, v);
		check_word("eret exl", 32'd0, {31'd0, v[STATUS_EXL]});
		write_reg(REG_STATUS, 32'h0000_0002);
		d = $urandom;
		next_cycle();
		eret  = 1'b1;
		wcp0  = 1'b1;
		waddr = REG_EPC;
		wsel  = REG_SEL0;
		wdata = d;
		check_fetch("eret epc forward", 1'b1, d);
		next_cycle();
		eret = 1'b0;
		wcp0 = 1'b0;
		read_reg(REG_STATUS, v);
		check_word("eret forward exl", 32'd0, {31'd0, v[STATUS_EXL]});
		read_reg(REG_EPC, v);
		check_word("eret forward epc kept", epc_exp, v);
	endtask

	task automatic test_interrupt(input logic is_sw);
		string     name;
		word_t     im;
		logic [7:0] ip_exp;
		word_t     v;
		name = is_sw ? "sw_irq" : "hw_irq";
		write_reg(REG_STATUS, '0);
		write_reg(REG_CAUSE, '0);
		if (is_sw)
		begin
			write_reg(REG_CAUSE, 32'h0000_0100);  // IP0
			im     = 32'h0000_0100;
			ip_exp = 8'h01;
		end
		else
		begin
			next_cycle();
			int_i  = 6'b000001;  // line 0 maps to IM2
			im     = 32'h0000_0400;
			ip_exp = 8'h04;
		end
		write_reg(REG_STATUS, im);
		check_fetch({name, " ie clear"}, 1'b0, '0);
		write_reg(REG_STATUS, 32'h0000_0001);
		check_fetch({name, " im clear"}, 1'b0, '0);
		write_reg(REG_STATUS, im | 32'h3);
		check_fetch({name, " exl set"}, 1'b0, '0);
		write_reg(REG_STATUS, im | 32'h1);
		check_fetch({name, " taken"}, 1'b1, EXC_VEC);
		read_reg(REG_CAUSE, v);
		check_code({name, " exccode"}, EXC_INT, v[CAUSE_EXC_HI:CAUSE_EXC_LO]);
		check_word({name, " ip"}, {24'd0, ip_exp}, {24'd0, v[CAUSE_IP_HI:CAUSE_IP_LO]});
		read_reg(REG_STATUS, v);
		check_word({name, " exl"}, 32'd1, {31'd0, v[STATUS_EXL]});
		next_cycle();
		int_i = '0;
		write_reg(REG_CAUSE, '0);
		write_reg(REG_STATUS, '0);
	endtask

	task automatic test_timer();
		word_t c;
		word_t v;
		int    n;
		logic  seen;
		write_reg(REG_STATUS, '0);
		c = 32'h0001_0000 + ($urandom & 32'h0000_ffff);
		write_reg(REG_COMPARE, c);
		cmp_exp = c;
		write_reg(REG_COUNT, c - 32'd20);
		read_reg(REG_COUNT, v);
		check_word("timer count", c - 32'd19, v);  // one cycle after the load
		n    = 0;
		seen = 1'b0;
		while (!seen && n < 100)
		begin
			read_reg(REG_CAUSE, v);
			seen = v[CAUSE_TI];
			n++;
		end
		if (!seen)
		begin
			timeout_errors++;
			$display("timer: Cause.TI did not set within 100 cycles");
		end
		write_reg(REG_STATUS, 32'h0000_8001);  // IM7 and IE
		check_fetch("timer irq", 1'b1, EXC_VEC);
		read_reg(REG_CAUSE, v);
		check_code("timer exccode", EXC_INT, v[CAUSE_EXC_HI:CAUSE_EXC_LO]);
		check_word("timer ip", 32'h80, {24'd0, v[CAUSE_IP_HI:CAUSE_IP_LO]});
		write_reg(REG_COMPARE, 32'hffff_0000);
		cmp_exp = 32'hffff_0000;
		read_reg(REG_CAUSE, v);
		check_word("timer ti cleared", 32'd0, {31'd0, v[CAUSE_TI]});
		write_reg(REG_STATUS, '0);
	endtask

	initial
	begin
		seed_ret         = $urandom(SEED);
		value_errors     = 0;
		timeout_errors   = 0;
		epc_exp          = '0;
		bad_exp          = '0;
		cmp_exp          = '0;
		rst_n            = 1'b0;
		wcp0             = 1'b0;
		eret             = 1'b0;
		is_delayslot     = 1'b0;
		waddr            = '0;
		raddr            = '0;
		wsel             = '0;
		rsel             = '0;
		wdata            = '0;
		victim_inst_addr = '0;
		badvaddr         = '0;
		exc_type         = '0;
		int_i            = '0;
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		test_reg_access();
		test_exc_entry();
		test_nesting();
		test_eret();
		test_interrupt(1'b0);
		test_interrupt(1'b1);
		test_timer();
		next_cycle();
		$display("errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
			value_errors, timeout_errors, dut0.u_assert.fail_count);
		if (value_errors + timeout_errors + dut0.u_assert.fail_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// whole-run limit
	initial
	begin
		repeat (5000) @(posedge clk);
		$display("watchdog: the test sequence did not finish within 5000 cycles");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- cp0_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_assert (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  eret,
	input  wire                  exc_en,
	input  wire cp0_pkg::word_t  pc_exc
);

	int fail_count = 0;  // failed assertions so far

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !exc_en)
		else
		begin
			$error("exc_en high while reset is asserted");
			fail_count++;
		end

	// fetch redirect address only valid with exc_en
	idle_pc_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!exc_en |-> (pc_exc == '0))
		else
		begin
			$error("pc_exc nonzero while exc_en is low");
			fail_count++;
		end

	eret_redirects: assert property (@(posedge clk) disable iff (!rst_n) eret |-> exc_en)
		else
		begin
			$error("eret without exc_en");
			fail_count++;
		end

endmodule

bind cp0_top cp0_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.eret(eret),
	.exc_en(exc_en),
	.pc_exc(pc_exc)
);

`default_nettype wire

//--- cp0_tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_tb_clk #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;  // free running
	end

endmodule

`default_nettype wire

//--- cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
	parameter cp0_pkg::word_t EXC_VECTOR = 32'hbfc0_0380,
	parameter cp0_pkg::word_t PRID_VALUE = 32'h0001_8000
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      wcp0,
	input  wire                      eret,
	input  wire                      is_delayslot,
	input  wire cp0_pkg::reg_addr_t  waddr,
	input  wire cp0_pkg::reg_addr_t  raddr,
	input  wire cp0_pkg::reg_sel_t   wsel,
	input  wire cp0_pkg::reg_sel_t   rsel,
	input  wire cp0_pkg::word_t      wdata,
	input  wire cp0_pkg::word_t      victim_inst_addr,
	input  wire cp0_pkg::word_t      badvaddr,
	input  wire cp0_pkg::exc_vec_t   exc_type,
	input  wire cp0_pkg::hw_irq_t    int_i,
	output cp0_pkg::word_t           cop0_data,
	output logic                     exc_en,
	output cp0_pkg::word_t           pc_exc
);
	import cp0_pkg::*;

	word_t     count, compare, epc, badvaddr_reg;
	logic      timer_int, status_ie, status_exl, cause_bd;
	logic [7:0] status_im, cause_ip;
	exc_code_t cause_code;

	logic      evt_req, evt_bd, evt_commit, evt_enter, evt_eret;
	evt_kind_t evt_kind;
	exc_code_t evt_code;
	word_t     evt_epc, evt_badvaddr;
	hw_irq_t   evt_ip;

	logic      wr_en;
	cp0_reg_e  wr_reg;
	word_t     wr_data;

	cp0_exc_unit #(.EXC_VECTOR(EXC_VECTOR)) u_exc (
		.eret, .wcp0, .waddr, .wsel, .wdata, .exc_type, .int_i, .timer_int,
		.status_ie, .status_exl, .status_im, .cause_sw(cause_ip[1:0]), .epc,
		.victim_inst_addr, .badvaddr, .is_delayslot, .exc_en, .pc_exc,
		.evt_req, .evt_kind, .evt_code, .evt_epc, .evt_bd, .evt_badvaddr, .evt_ip
	);

	cp0_write_arbiter u_arb (
		.wcp0, .waddr, .wsel, .wdata, .evt_req, .evt_kind, .status_exl,
		.wr_en, .wr_reg, .wr_data, .evt_commit, .evt_enter, .evt_eret
	);

	cp0_timer u_timer (
		.clk, .rst_n, .wr_en, .wr_reg, .wr_data, .count, .compare, .timer_int
	);

	cp0_regs u_regs (
		.clk, .rst_n, .wr_en, .wr_reg, .wr_data, .evt_commit, .evt_enter, .evt_eret,
		.evt_code, .evt_epc, .evt_bd, .evt_badvaddr, .evt_ip, .evt_kind,
		.status_ie, .status_exl, .status_im, .cause_code, .cause_ip, .cause_bd,
		.epc, .badvaddr(badvaddr_reg)
	);

	cp0_read_mux #(.PRID_VALUE(PRID_VALUE)) u_rd (
		.raddr, .rsel, .wcp0, .waddr, .wsel, .wdata, .count, .compare, .timer_int,
		.status_ie, .status_exl, .status_im, .cause_code, .cause_ip, .cause_bd,
		.epc, .badvaddr(badvaddr_reg), .cop0_data
	);

endmodule

`default_nettype wire

//--- cp0_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_read_mux #(
	parameter cp0_pkg::word_t PRID_VALUE = 32'h0001_8000
) (
	input  wire cp0_pkg::reg_addr_t  raddr,
	input  wire cp0_pkg::reg_sel_t   rsel,
	input  wire                      wcp0,
	input  wire cp0_pkg::reg_addr_t  waddr,
	input  wire cp0_pkg::reg_sel_t   wsel,
	input  wire cp0_pkg::word_t      wdata,
	input  wire cp0_pkg::word_t      count,
	input  wire cp0_pkg::word_t      compare,
	input  wire                      timer_int,
	input  wire                      status_ie,
	input  wire                      status_exl,
	input  wire [7:0]                status_im,
	input  wire cp0_pkg::exc_code_t  cause_code,
	input  wire [7:0]                cause_ip,
	input  wire                      cause_bd,
	input  wire cp0_pkg::word_t      epc,
	input  wire cp0_pkg::word_t      badvaddr,
	output cp0_pkg::word_t           cop0_data
);
	import cp0_pkg::*;

	logic wr_hit;

	assign wr_hit = wcp0 && (waddr == raddr) && (wsel == rsel);  // same-cycle mtc0

	always_comb
	begin
		cop0_data = '0;
		if (rsel == REG_SEL0)
		begin
			case (raddr)
				REG_BADVADDR: cop0_data = badvaddr;
				REG_COUNT:    cop0_data = wr_hit ? wdata : count;
				REG_COMPARE:  cop0_data = wr_hit ? wdata : compare;
				REG_EPC:      cop0_data = wr_hit ? wdata : epc;
				REG_PRID:     cop0_data = PRID_VALUE;
				REG_STATUS:
				begin
					cop0_data[STATUS_BEV] = 1'b1;
					cop0_data[STATUS_IM_HI:STATUS_IM_LO] =
						wr_hit ? wdata[STATUS_IM_HI:STATUS_IM_LO] : status_im;
					cop0_data[STATUS_EXL] = wr_hit ? wdata[STATUS_EXL] : status_exl;
					cop0_data[STATUS_IE]  = wr_hit ? wdata[STATUS_IE] : status_ie;
				end
				REG_CAUSE:
				begin
					cop0_data[CAUSE_BD] = cause_bd;
					cop0_data[CAUSE_TI] = timer_int;
					cop0_data[CAUSE_IP_HI:CAUSE_IP_LO] = cause_ip;
					if (wr_hit)
						cop0_data[CAUSE_IP_LO+1:CAUSE_IP_LO] = wdata[CAUSE_IP_LO+1:CAUSE_IP_LO];
					cop0_data[CAUSE_EXC_HI:CAUSE_EXC_LO] = cause_code;
				end
				default:      cop0_data = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      wr_en,
	input  wire cp0_pkg::cp0_reg_e   wr_reg,
	input  wire cp0_pkg::word_t      wr_data,
	input  wire                      evt_commit,
	input  wire                      evt_enter,
	input  wire                      evt_eret,
	input  wire cp0_pkg::exc_code_t  evt_code,
	input  wire cp0_pkg::word_t      evt_epc,
	input  wire                      evt_bd,
	input  wire cp0_pkg::word_t      evt_badvaddr,
	input  wire cp0_pkg::hw_irq_t    evt_ip,
	input  wire cp0_pkg::evt_kind_t  evt_kind,
	output logic                     status_ie,
	output logic                     status_exl,
	output logic [7:0]               status_im,
	output cp0_pkg::exc_code_t       cause_code,
	output logic [7:0]               cause_ip,
	output logic                     cause_bd,
	output cp0_pkg::word_t           epc,
	output cp0_pkg::word_t           badvaddr
);
	import cp0_pkg::*;

	logic addr_exc;

	// only the address errors load BadVAddr
	assign addr_exc = (evt_kind == EVT_EXC) && ((evt_code == EXC_ADEL) || (evt_code == EXC_ADES));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			status_ie  <= 1'b0;
			status_exl <= 1'b0;
			status_im  <= '0;
			cause_code <= '0;
			cause_ip   <= '0;
			cause_bd   <= 1'b0;
			epc        <= '0;
			badvaddr   <= '0;
		end
		else if (evt_eret)
		begin
			status_exl <= 1'b0;  // back to normal level
		end
		else if (evt_commit)
		begin
			cause_code    <= evt_code;  // recorded even when nested
			cause_ip[7:2] <= evt_ip;
			if (evt_enter)
			begin
				status_exl <= 1'b1;
				epc        <= evt_epc;
				cause_bd   <= evt_bd;
				if (addr_exc)
					badvaddr <= evt_badvaddr;
			end
		end
		else if (wr_en)
		begin
			case (wr_reg)
				WR_STATUS:
				begin
					status_ie  <= wr_data[STATUS_IE];
					status_exl <= wr_data[STATUS_EXL];
					status_im  <= wr_data[STATUS_IM_HI:STATUS_IM_LO];
				end
				WR_CAUSE:
				begin
					cause_ip[1:0] <= wr_data[CAUSE_IP_LO+1:CAUSE_IP_LO];  // sw interrupt bits only
				end
				WR_EPC:
				begin
					epc <= wr_data;
				end
				default:
				begin
					// BadVAddr is read-only to software, timer owns Count and Compare
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- cp0_write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_write_arbiter (
	input  wire                      wcp0,
	input  wire cp0_pkg::reg_addr_t  waddr,
	input  wire cp0_pkg::reg_sel_t   wsel,
	input  wire cp0_pkg::word_t      wdata,
	input  wire                      evt_req,
	input  wire cp0_pkg::evt_kind_t  evt_kind,
	input  wire                      status_exl,
	output logic                     wr_en,
	output cp0_pkg::cp0_reg_e        wr_reg,
	output cp0_pkg::word_t           wr_data,
	output logic                     evt_commit,
	output logic                     evt_enter,
	output logic                     evt_eret
);
	import cp0_pkg::*;

	cp0_reg_e sw_reg;

	// mtc0 address decode
	always_comb
	begin
		sw_reg = WR_NONE;
		if (wsel == REG_SEL0)
		begin
			case (waddr)
				REG_STATUS:   sw_reg = WR_STATUS;
				REG_CAUSE:    sw_reg = WR_CAUSE;
				REG_EPC:      sw_reg = WR_EPC;
				REG_BADVADDR: sw_reg = WR_BADVADDR;
				REG_COUNT:    sw_reg = WR_COUNT;
				REG_COMPARE:  sw_reg = WR_COMPARE;
				default:      sw_reg = WR_NONE;  // PRId and unknown
			endcase
		end
	end

	// eret, exception and interrupt come ranked from the exception unit
	assign evt_commit = evt_req;
	assign evt_eret   = evt_req && (evt_kind == EVT_ERET);
	assign evt_enter  = evt_req && (evt_kind != EVT_ERET) && !status_exl;  // no nested entry

	// software write only gets the bus when no event is committing
	assign wr_en   = wcp0 && !evt_req && (sw_reg != WR_NONE);
	assign wr_reg  = wr_en ? sw_reg : WR_NONE;
	assign wr_data = wr_en ? wdata : '0;

endmodule

`default_nettype wire

//--- cp0_exc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_exc_unit #(
	parameter cp0_pkg::word_t EXC_VECTOR = 32'hbfc0_0380
) (
	input  wire                      eret,
	input  wire                      wcp0,
	input  wire cp0_pkg::reg_addr_t  waddr,
	input  wire cp0_pkg::reg_sel_t   wsel,
	input  wire cp0_pkg::word_t      wdata,
	input  wire cp0_pkg::exc_vec_t   exc_type,
	input  wire cp0_pkg::hw_irq_t    int_i,
	input  wire                      timer_int,
	input  wire                      status_ie,
	input  wire                      status_exl,
	input  wire [7:0]                status_im,
	input  wire cp0_pkg::sw_irq_t    cause_sw,
	input  wire cp0_pkg::word_t      epc,
	input  wire cp0_pkg::word_t      victim_inst_addr,
	input  wire cp0_pkg::word_t      badvaddr,
	input  wire                      is_delayslot,
	output logic                     exc_en,
	output cp0_pkg::word_t           pc_exc,
	output logic                     evt_req,
	output cp0_pkg::evt_kind_t       evt_kind,
	output cp0_pkg::exc_code_t       evt_code,
	output cp0_pkg::word_t           evt_epc,
	output logic                     evt_bd,
	output cp0_pkg::word_t           evt_badvaddr,
	output cp0_pkg::hw_irq_t         evt_ip
);
	import cp0_pkg::*;

	hw_irq_t   hw_src;
	hw_irq_t   hw_pend;
	sw_irq_t   sw_pend;
	logic      int_take;
	logic      exc_any;
	logic      epc_fwd;
	exc_code_t exc_code;

	assign hw_src  = {int_i[5] | timer_int, int_i[4:0]};  // timer shares line 5
	assign hw_pend = status_exl ? '0 : (hw_src & status_im[7:2]);
	assign sw_pend = status_exl ? '0 : (cause_sw & status_im[1:0]);
	assign int_take = status_ie && ((hw_pend != '0) || (sw_pend != '0));

	assign exc_any = exc_type[EXCB_ADEL] | exc_type[EXCB_ADES] | exc_type[EXCB_SYS]
		| exc_type[EXCB_BP] | exc_type[EXCB_RI0] | exc_type[EXCB_RI1]
		| exc_type[EXCB_OV] | exc_type[EXCB_TR];

	// highest priority flag wins, Int when no flag is kept
	always_comb
	begin
		if (exc_type[EXCB_ADEL])
			exc_code = EXC_ADEL;
		else if (exc_type[EXCB_ADES])
			exc_code = EXC_ADES;
		else if (exc_type[EXCB_SYS])
			exc_code = EXC_SYS;
		else if (exc_type[EXCB_BP])
			exc_code = EXC_BP;
		else if (exc_type[EXCB_RI0] || exc_type[EXCB_RI1])
			exc_code = EXC_RI;
		else if (exc_type[EXCB_OV])
			exc_code = EXC_OV;
		else if (exc_type[EXCB_TR])
			exc_code = EXC_TR;
		else
			exc_code = EXC_INT;
	end

	// mtc0 to EPC in the same cycle as eret is still in flight
	assign epc_fwd = wcp0 && (waddr == REG_EPC) && (wsel == REG_SEL0);

	always_comb
	begin
		if (eret)
			pc_exc = epc_fwd ? wdata : epc;
		else if (exc_any || int_take)
			pc_exc = EXC_VECTOR;
		else
			pc_exc = '0;
	end

	assign exc_en  = eret || exc_any || int_take;
	assign evt_req = exc_en;

	always_comb
	begin
		if (eret)
			evt_kind = EVT_ERET;
		else if (exc_any)
			evt_kind = EVT_EXC;
		else
			evt_kind = EVT_INT;
	end

	assign evt_code = exc_code;
	assign evt_bd   = is_delayslot;
	assign evt_epc  = is_delayslot ? (victim_inst_addr - 32'd4) : victim_inst_addr;
	assign evt_ip   = hw_pend;

	// misaligned fetch takes priority over a bad data address
	assign evt_badvaddr = ((exc_code == EXC_ADEL) && (victim_inst_addr[1:0] != 2'b00)) ?
		victim_inst_addr : badvaddr;

endmodule

`default_nettype wire

//--- cp0_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_timer (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     wr_en,
	input  wire cp0_pkg::cp0_reg_e  wr_reg,
	input  wire cp0_pkg::word_t     wr_data,
	output cp0_pkg::word_t          count,
	output cp0_pkg::word_t          compare,
	output logic                    timer_int
);
	import cp0_pkg::*;

	logic count_wr;
	logic compare_wr;
	logic match;

	assign count_wr   = wr_en && (wr_reg == WR_COUNT);
	assign compare_wr = wr_en && (wr_reg == WR_COMPARE);
	assign match      = (count == compare) && (count != '0);  // zero count never fires

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count <= '0;
		end
		else if (count_wr)
		begin
			count <= wr_data;  // counts on from here next cycle
		end
		else
		begin
			count <= count + 32'd1;  // wraps at full word
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			compare   <= '0;
			timer_int <= 1'b0;
		end
		else if (compare_wr)
		begin
			compare   <= wr_data;
			timer_int <= 1'b0;  // compare write acks the timer
		end
		else if (match)
		begin
			timer_int <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- cp0_pkg.sv
`default_nettype none

package cp0_pkg;

	typedef logic [31:0] word_t;      // data, address or register value
	typedef logic [4:0]  reg_addr_t;  // coprocessor register number
	typedef logic [2:0]  reg_sel_t;
	typedef logic [31:0] exc_vec_t;   // exception flags from the pipeline
	typedef logic [4:0]  exc_code_t;
	typedef logic [5:0]  hw_irq_t;
	typedef logic [1:0]  sw_irq_t;
	typedef logic [1:0]  evt_kind_t;  // kind of a commit request

	// registers carried on the write bus
	typedef enum logic [2:0] {
		WR_NONE,
		WR_STATUS,
		WR_CAUSE,
		WR_EPC,
		WR_BADVADDR,
		WR_COUNT,
		WR_COMPARE
	} cp0_reg_e;

	localparam evt_kind_t EVT_ERET = 2'd0;
	localparam evt_kind_t EVT_EXC  = 2'd1;
	localparam evt_kind_t EVT_INT  = 2'd2;

	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;  // load or fetch misaligned
	localparam exc_code_t EXC_ADES = 5'd5;  // store misaligned
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;
	localparam exc_code_t EXC_RI   = 5'd10;
	localparam exc_code_t EXC_OV   = 5'd12;
	localparam exc_code_t EXC_TR   = 5'd13;

	// flag positions in exc_type, other bits are ignored
	localparam int EXCB_ADEL = 4;
	localparam int EXCB_ADES = 5;
	localparam int EXCB_SYS  = 8;
	localparam int EXCB_BP   = 9;
	localparam int EXCB_RI0  = 10;
	localparam int EXCB_RI1  = 11;
	localparam int EXCB_OV   = 12;
	localparam int EXCB_TR   = 13;

	localparam reg_addr_t REG_BADVADDR = 5'd8;
	localparam reg_addr_t REG_COUNT    = 5'd9;
	localparam reg_addr_t REG_COMPARE  = 5'd11;
	localparam reg_addr_t REG_STATUS   = 5'd12;
	localparam reg_addr_t REG_CAUSE    = 5'd13;
	localparam reg_addr_t REG_EPC      = 5'd14;
	localparam reg_addr_t REG_PRID     = 5'd15;
	localparam reg_sel_t  REG_SEL0     = 3'd0;  // every kept register sits on select 0

	localparam int STATUS_IE    = 0;
	localparam int STATUS_EXL   = 1;
	localparam int STATUS_IM_LO = 8;
	localparam int STATUS_IM_HI = 15;
	localparam int STATUS_BEV   = 22;  // reads as one

	localparam int CAUSE_EXC_LO = 2;
	localparam int CAUSE_EXC_HI = 6;
	localparam int CAUSE_IP_LO  = 8;
	localparam int CAUSE_IP_HI  = 15;
	localparam int CAUSE_TI     = 30;
	localparam int CAUSE_BD     = 31;

endpackage

`default_nettype wire
